//--- src/packer_pkg.sv
//////////////////////////////
// stream packer constants
// widths, lane count and packing ratio
// shared by the RTL and the testbench
//////////////////////////////
package packer_pkg;

    // narrow side, one byte per beat
    localparam int slim_w = 8;

    // wide side, one packed word
    localparam int wide_w = 32;

    // narrow beats per wide word
    localparam int ratio = wide_w / slim_w;

    // one keep bit per byte of the wide word
    localparam int keep_w = wide_w / 8;

    // number of width combiners
    localparam int num_lanes = 4;

    // lane or destination number
    localparam int lane_w = $clog2(num_lanes);

    // byte-slot counter inside a combiner
    localparam int cnt_w = $clog2(ratio);

    // this packer is only built for a 4:1 ratio with byte beats;
    // the slot-to-byte mapping in the combiner follows from that
    localparam bit ratio_ok = (ratio == 4) && (slim_w == 8);

    // lane used as the round-robin start point after reset,
    // so lane 0 is searched first
    localparam int rr_reset_lane = num_lanes - 1;

endpackage

//--- src/lane_dispatch.sv
//////////////////////////////
// lane dispatch
// steers each narrow beat to the combiner
// named by its destination field
//////////////////////////////
`timescale 1ns/1ps

module lane_dispatch (
    // narrow input handshake
    input  logic                               in_valid,
    output logic                               in_ready,
    input  logic [packer_pkg::lane_w-1:0]      in_dest,

    // one valid/ready pair per combiner
    output logic [packer_pkg::num_lanes-1:0]   slim_valid,
    input  logic [packer_pkg::num_lanes-1:0]   slim_ready
);

    // selected lane as a one-hot mask
    logic [packer_pkg::num_lanes-1:0] dest_hot;

    // decode of the destination field
    always_comb begin
        for (int n = 0; n < packer_pkg::num_lanes; n++) begin
            dest_hot[n] = (in_dest == packer_pkg::lane_w'(n));
        end
    end

    // only the chosen combiner sees the beat
    always_comb begin
        for (int n = 0; n < packer_pkg::num_lanes; n++) begin
            slim_valid[n] = in_valid && dest_hot[n];
        end
    end

    // the source stalls only on the lane it is
    // writing to, other lanes may be busy draining
    always_comb begin
        in_ready = 1'b0;
        for (int n = 0; n < packer_pkg::num_lanes; n++) begin
            if (dest_hot[n]) begin
                in_ready = slim_ready[n];
            end
        end
    end

    // data, last and user fan out directly in the top
    // level, nothing of the payload passes through here

endmodule

//--- src/width_combiner.sv
//////////////////////////////
// width combiner
// packs four byte beats into one 32-bit word,
// first beat in the top byte, with keep/last/user
//////////////////////////////
`timescale 1ns/1ps

module width_combiner (
    input  logic                                clock,
    input  logic                                rst_n,

    // narrow side
    input  logic                                slim_valid,
    output logic                                slim_ready,
    input  logic [packer_pkg::slim_w-1:0]       slim_data,
    input  logic                                slim_last,
    input  logic                                slim_user,

    // wide side
    output logic                                wide_valid,
    input  logic                                wide_ready,
    output logic [packer_pkg::wide_w-1:0]       wide_data,
    output logic [packer_pkg::keep_w-1:0]       wide_keep,
    output logic                                wide_last,
    output logic                                wide_user
);

    // slot of the next byte, 0 is the top byte
    logic [packer_pkg::cnt_w-1:0]   cnt;

    // word under collection
    logic [packer_pkg::wide_w-1:0]  col_data;
    logic [packer_pkg::keep_w-1:0]  col_keep;

    // collection word with the current beat merged in
    logic [packer_pkg::wide_w-1:0]  merge_data;
    logic [packer_pkg::keep_w-1:0]  merge_keep;

    logic                           accept;
    logic                           close;

    // free when nothing is held, or the held word
    // leaves in this same cycle
    assign slim_ready = !wide_valid || wide_ready;

    assign accept = slim_valid && slim_ready;

    // word ends on the fourth byte or on a packet's last beat
    assign close = accept &&
                   (slim_last || cnt == packer_pkg::cnt_w'(packer_pkg::ratio - 1));

    // place the beat into its byte and blank bytes
    // that never got written in this word
    always_comb begin
        merge_data = col_data;
        merge_keep = col_keep;
        for (int b = 0; b < packer_pkg::keep_w; b++) begin
            // byte b is filled by slot ratio-1-b
            if (cnt == packer_pkg::cnt_w'(packer_pkg::ratio - 1 - b)) begin
                merge_data[b*packer_pkg::slim_w +: packer_pkg::slim_w] = slim_data;
                merge_keep[b] = 1'b1;
            end
            if (!merge_keep[b]) begin
                merge_data[b*packer_pkg::slim_w +: packer_pkg::slim_w] = '0;
            end
        end
    end

    // control state
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cnt        <= '0;
            col_keep   <= '0;
            wide_valid <= 1'b0;
        end else begin
            if (wide_valid && wide_ready) begin
                wide_valid <= 1'b0;
            end
            if (accept) begin
                if (close) begin
                    // restart with an empty keep mask
                    cnt        <= '0;
                    col_keep   <= '0;
                    wide_valid <= 1'b1;
                end else begin
                    cnt      <= cnt + 1'b1;
                    col_keep <= merge_keep;
                end
            end
        end
    end

    // collection bytes, stale ones are masked by keep
    always_ff @(posedge clock) begin
        if (accept) begin
            col_data <= merge_data;
        end
    end

    // output word, held until the drain takes it
    always_ff @(posedge clock) begin
        if (close) begin
            wide_data <= merge_data;
            wide_keep <= merge_keep;
            wide_last <= slim_last;
            // user of the closing beat
            wide_user <= slim_user;
        end
    end

endmodule

//--- src/lane_drain.sv
//////////////////////////////
// lane drain
// round-robin merge of the combiner words
// onto one output tagged with its lane
//////////////////////////////
`timescale 1ns/1ps

module lane_drain (
    input  logic                                                clock,
    input  logic                                                rst_n,

    // flattened combiner outputs, lane n in slice n
    input  logic [packer_pkg::num_lanes-1:0]                    wide_valid,
    output logic [packer_pkg::num_lanes-1:0]                    wide_ready,
    input  logic [packer_pkg::num_lanes*packer_pkg::wide_w-1:0] wide_data,
    input  logic [packer_pkg::num_lanes*packer_pkg::keep_w-1:0] wide_keep,
    input  logic [packer_pkg::num_lanes-1:0]                    wide_last,
    input  logic [packer_pkg::num_lanes-1:0]                    wide_user,

    // merged output
    output logic                                                out_valid,
    input  logic                                                out_ready,
    output logic [packer_pkg::wide_w-1:0]                       out_data,
    output logic [packer_pkg::keep_w-1:0]                       out_keep,
    output logic [packer_pkg::lane_w-1:0]                       out_lane,
    output logic                                                out_last,
    output logic                                                out_user
);

    logic [packer_pkg::lane_w-1:0] last_served;
    logic [packer_pkg::lane_w-1:0] grant;
    logic                          locked;
    logic [packer_pkg::lane_w-1:0] pick;
    logic [packer_pkg::lane_w-1:0] sel;

    // search starts one past the last lane served and wraps
    always_comb begin
        logic [packer_pkg::lane_w-1:0] cand;
        logic                          found;
        pick  = last_served;
        found = 1'b0;
        for (int i = 1; i <= packer_pkg::num_lanes; i++) begin
            cand = last_served + packer_pkg::lane_w'(i);
            if (!found && wide_valid[cand]) begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    // a stalled word keeps its lane
    assign sel = locked ? grant : pick;

    assign out_valid = wide_valid[sel];
    assign out_data  = wide_data[sel*packer_pkg::wide_w +: packer_pkg::wide_w];
    assign out_keep  = wide_keep[sel*packer_pkg::keep_w +: packer_pkg::keep_w];
    assign out_last  = wide_last[sel];
    assign out_user  = wide_user[sel];
    assign out_lane  = sel;

    // ready goes back only to the granted lane
    always_comb begin
        wide_ready      = '0;
        wide_ready[sel] = out_ready;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            last_served <= packer_pkg::lane_w'(packer_pkg::rr_reset_lane);
            grant       <= '0;
            locked      <= 1'b0;
        end else if (out_valid && out_ready) begin
            last_served <= sel;
            locked      <= 1'b0;
        end else if (out_valid) begin
            grant  <= sel;
            locked <= 1'b1;
        end
    end

endmodule

//--- src/stream_packer_top.sv
//////////////////////////////
// stream packer top
// dispatch, four combiners and the drain
//////////////////////////////
`timescale 1ns/1ps

module stream_packer_top (
    input  logic                              clock,
    input  logic                              rst_n,

    // narrow input stream
    input  logic                              in_valid,
    output logic                              in_ready,
    input  logic [packer_pkg::slim_w-1:0]     in_data,
    input  logic [packer_pkg::lane_w-1:0]     in_dest,
    input  logic                              in_last,
    input  logic                              in_user,

    // packed output stream
    output logic                              out_valid,
    input  logic                              out_ready,
    output logic [packer_pkg::wide_w-1:0]     out_data,
    output logic [packer_pkg::keep_w-1:0]     out_keep,
    output logic [packer_pkg::lane_w-1:0]     out_lane,
    output logic                              out_last,
    output logic                              out_user
);

    logic [packer_pkg::num_lanes-1:0]                    slim_valid;
    logic [packer_pkg::num_lanes-1:0]                    slim_ready;
    logic [packer_pkg::num_lanes-1:0]                    wide_valid;
    logic [packer_pkg::num_lanes-1:0]                    wide_ready;
    logic [packer_pkg::num_lanes*packer_pkg::wide_w-1:0] wide_data;
    logic [packer_pkg::num_lanes*packer_pkg::keep_w-1:0] wide_keep;
    logic [packer_pkg::num_lanes-1:0]                    wide_last;
    logic [packer_pkg::num_lanes-1:0]                    wide_user;

    lane_dispatch i_dispatch (
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_dest    (in_dest),
        .slim_valid (slim_valid),
        .slim_ready (slim_ready)
    );

    // payload is shared, only valid is steered
    for (genvar n = 0; n < packer_pkg::num_lanes; n++) begin : g_lane
        width_combiner i_comb (
            .clock      (clock),
            .rst_n      (rst_n),
            .slim_valid (slim_valid[n]),
            .slim_ready (slim_ready[n]),
            .slim_data  (in_data),
            .slim_last  (in_last),
            .slim_user  (in_user),
            .wide_valid (wide_valid[n]),
            .wide_ready (wide_ready[n]),
            .wide_data  (wide_data[n*packer_pkg::wide_w +: packer_pkg::wide_w]),
            .wide_keep  (wide_keep[n*packer_pkg::keep_w +: packer_pkg::keep_w]),
            .wide_last  (wide_last[n]),
            .wide_user  (wide_user[n])
        );
    end

    lane_drain i_drain (
        .clock      (clock),
        .rst_n      (rst_n),
        .wide_valid (wide_valid),
        .wide_ready (wide_ready),
        .wide_data  (wide_data),
        .wide_keep  (wide_keep),
        .wide_last  (wide_last),
        .wide_user  (wide_user),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .out_keep   (out_keep),
        .out_lane   (out_lane),
        .out_last   (out_last),
        .out_user   (out_user)
    );

endmodule

//--- verif/stream_packer_tb.sv
//////////////////////////////
// stream packer testbench
// table-driven packets, reference packer,
// per-lane scoreboard and back-pressure
//////////////////////////////
`timescale 1ns/1ps

module stream_packer_tb;

    // one packet row
    // ilv sends the same length to all four lanes in turn
    typedef struct packed {
        logic [1:0] lane;
        logic [3:0] len;
        logic       user;
        logic       bp;
        logic       ilv;
    } pkt_t;

    localparam int n_tests = 12;
    localparam int ew = packer_pkg::wide_w + packer_pkg::keep_w + 2;
    localparam pkt_t tbl [n_tests] = '{
        '{2'd0, 4'd4,  1'b1, 1'b0, 1'b0},
        '{2'd1, 4'd8,  1'b0, 1'b0, 1'b0},
        '{2'd2, 4'd1,  1'b1, 1'b0, 1'b0},
        '{2'd3, 4'd2,  1'b0, 1'b0, 1'b0},
        '{2'd0, 4'd3,  1'b1, 1'b0, 1'b0},
        '{2'd1, 4'd5,  1'b1, 1'b0, 1'b0},
        '{2'd2, 4'd7,  1'b0, 1'b0, 1'b0},
        '{2'd3, 4'd11, 1'b1, 1'b0, 1'b0},
        '{2'd0, 4'd6,  1'b1, 1'b0, 1'b1},
        '{2'd0, 4'd9,  1'b0, 1'b1, 1'b1},
        '{2'd2, 4'd10, 1'b1, 1'b1, 1'b0},
        '{2'd1, 4'd4,  1'b1, 1'b1, 1'b1}
    };

    logic clock = 1'b0;
    logic rst_n;
    logic in_valid, in_ready, in_last, in_user;
    logic [packer_pkg::slim_w-1:0] in_data;
    logic [packer_pkg::lane_w-1:0] in_dest;
    logic out_valid, out_ready, out_last, out_user;
    logic [packer_pkg::wide_w-1:0] out_data;
    logic [packer_pkg::keep_w-1:0] out_keep;
    logic [packer_pkg::lane_w-1:0] out_lane;

    integer seed = 32'hffb4;
    integer rnd;
    int     errors = 0;
    int     words = 0;
    logic   bp_on = 1'b0;

    // expected words per lane as {user, last, keep, data}
    logic [ew-1:0] exp_q [packer_pkg::num_lanes][$];
    logic [ew-1:0] mon_word;
    logic [packer_pkg::wide_w-1:0] acc_data [packer_pkg::num_lanes];
    logic [packer_pkg::keep_w-1:0] acc_keep [packer_pkg::num_lanes];
    int            acc_cnt [packer_pkg::num_lanes];

    // stall tracking for the hold check
    logic held = 1'b0;
    logic [packer_pkg::wide_w-1:0] held_data;
    logic [packer_pkg::lane_w-1:0] held_lane;

    stream_packer_top i_dut (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .in_dest   (in_dest),
        .in_last   (in_last),
        .in_user   (in_user),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_keep  (out_keep),
        .out_lane  (out_lane),
        .out_last  (out_last),
        .out_user  (out_user)
    );

    always #10 clock = ~clock;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t ns %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // reference packer with the first byte in the top slot
    task automatic model_beat(input logic [packer_pkg::lane_w-1:0] lane,
                              input logic [7:0] b, input logic last, input logic u);
        int s;
        s = acc_cnt[lane];
        acc_data[lane][(packer_pkg::wide_w - 1 - packer_pkg::slim_w * s) -: packer_pkg::slim_w] = b;
        acc_keep[lane][packer_pkg::keep_w - 1 - s] = 1'b1;
        if (last || s == packer_pkg::keep_w - 1) begin
            exp_q[lane].push_back({u, last, acc_keep[lane], acc_data[lane]});
            acc_data[lane] = '0;
            acc_keep[lane] = '0;
            acc_cnt[lane] = 0;
        end else begin
            acc_cnt[lane] = s + 1;
        end
    endtask

    // entered and left 1 ns after a rising edge
    task automatic send_beat(input logic [packer_pkg::lane_w-1:0] lane,
                             input logic [7:0] b, input logic last, input logic u);
        in_valid = 1'b1;
        in_dest  = lane;
        in_data  = b;
        in_last  = last;
        in_user  = u;
        @(negedge clock);
        while (!in_ready) @(negedge clock);
        @(posedge clock);
        #1;
        in_valid = 1'b0;
    endtask

    function automatic int words_pending();
        int n;
        n = 0;
        for (int l = 0; l < packer_pkg::num_lanes; l++) begin
            n += exp_q[l].size();
        end
        return n;
    endfunction

    task automatic run_test(input int t);
        int errs_before;
        int nl;
        logic [packer_pkg::lane_w-1:0] lane;
        logic [7:0] b;
        logic last;
        logic u;
        errs_before = errors;
        bp_on = tbl[t].bp;
        nl = tbl[t].ilv ? packer_pkg::num_lanes : 1;
        for (int k = 0; k < int'(tbl[t].len); k++) begin
            for (int j = 0; j < nl; j++) begin
                lane = tbl[t].ilv ? packer_pkg::lane_w'(j) : tbl[t].lane;
                rnd  = $random(seed);
                b    = rnd[7:0];
                last = (k == int'(tbl[t].len) - 1);
                // earlier beats carry a random user bit
                u    = last ? tbl[t].user : rnd[8];
                model_beat(lane, b, last, u);
                send_beat(lane, b, last, u);
            end
        end
        while (words_pending() != 0) @(negedge clock);
        bp_on = 1'b0;
        @(posedge clock);
        #1;
        $display("test %0d lane %0d len %0d user %0d bp %0d ilv %0d: %s", t, tbl[t].lane,
                 tbl[t].len, tbl[t].user, tbl[t].bp, tbl[t].ilv,
                 (errors == errs_before) ? "ok" : "mismatch");
    endtask

    // ready drawn at the falling edge, applied just after the rising edge
    // random only while back-pressure is on
    initial begin
        integer r;
        out_ready = 1'b1;
        forever begin
            @(negedge clock);
            r = $random(seed);
            @(posedge clock);
            #1;
            out_ready = bp_on ? r[0] : 1'b1;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clock) begin
        if (rst_n) begin
            if (held) begin
                check("out_valid held", out_valid, 1);
                check("out_data held", out_data, held_data);
                check("out_lane held", out_lane, held_lane);
            end
            held      = out_valid && !out_ready;
            held_data = out_data;
            held_lane = out_lane;
            if (out_valid && out_ready) begin
                if (exp_q[out_lane].size() == 0) begin
                    $display("word on lane %0d at %0t ns was never sent", out_lane, $time);
                    errors++;
                end else begin
                    mon_word = exp_q[out_lane].pop_front();
                    check("out_data", out_data, mon_word[packer_pkg::wide_w-1:0]);
                    check("out_keep", out_keep, mon_word[ew-3:packer_pkg::wide_w]);
                    check("out_last", out_last, mon_word[ew-2]);
                    check("out_user", out_user, mon_word[ew-1]);
                    words++;
                end
            end
        end
    end

    // limit grows with the number of beats in the table
    initial begin
        int beats;
        beats = 0;
        for (int t = 0; t < n_tests; t++) begin
            beats += int'(tbl[t].len) * (tbl[t].ilv ? packer_pkg::num_lanes : 1);
        end
        repeat (beats * 8 + 200) @(posedge clock);
        $display("timeout, output words did not drain after %0d clock periods", beats * 8 + 200);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        in_valid = 1'b0;
        in_data  = '0;
        in_dest  = '0;
        in_last  = 1'b0;
        in_user  = 1'b0;
        rst_n    = 1'b0;
        for (int l = 0; l < packer_pkg::num_lanes; l++) begin
            acc_data[l] = '0;
            acc_keep[l] = '0;
            acc_cnt[l]  = 0;
        end
        repeat (8) @(posedge clock);
        #1;
        rst_n = 1'b1;
        @(negedge clock);
        check("out_valid", out_valid, 0);
        check("in_ready", in_ready, 1);
        $display("reset check: %s", (errors == 0) ? "ok" : "mismatch");
        @(posedge clock);
        #1;
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d words checked, %0d errors", n_tests, words, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- files.f
src/packer_pkg.sv
src/lane_dispatch.sv
src/width_combiner.sv
src/lane_drain.sv
src/stream_packer_top.sv
verif/stream_packer_tb.sv

//--- run.sh
#!/bin/sh
# build and run the stream packer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module stream_packer_tb -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -qF '*** FAILED ***' sim.log && { echo "simulation failed"; exit 1; }
echo "simulation finished without failures"
exit 0
